/* filelist.f */
+incdir+hw
hw/sock_mem_pkg.sv
hw/sock_dcr_pkg.sv
hw/sock_dcr_regs.sv
hw/sock_core.sv
hw/sock_mem_arb.sv
hw/sock_socket.sv
verif/sock_mem_model.sv
verif/tb_socket.sv

/* Makefile */
TOP = tb_socket

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

obj_dir/V$(TOP): filelist.f hw/*.sv hw/*.svh verif/*.sv
	verilator --binary --timing --top-module $(TOP) -f filelist.f

lint:
	verilator --lint-only --timing --top-module $(TOP) -f filelist.f

clean:
	rm -rf obj_dir

/* verif/tb_socket.sv */
`include "sock_params.svh"

`default_nettype none

module tb_socket import sock_mem_pkg::*; import sock_dcr_pkg::*; ();

    localparam int N = `SOCK_SIZE;

    logic     clk;
    logic     reset;
    dcr_req_t dcr;
    mem_req_t mem_req;
    mem_rsp_t mem_rsp;
    logic     busy;
    logic [31:0] lcg_state;

    sock_socket uut (
        .clk     (clk),
        .reset   (reset),
        .dcr     (dcr),
        .mem_req (mem_req),
        .mem_rsp (mem_rsp),
        .busy    (busy)
    );

    sock_mem_model mem_model (
        .clk     (clk),
        .reset   (reset),
        .mem_req (mem_req),
        .mem_rsp (mem_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_eq(input string name, input logic [31:0] actual,
                            input logic [31:0] expected);
        if (actual !== expected) begin
            stop_with_error($sformatf("mismatch at %0t: %s is %h, expected %h",
                                      $time, name, actual, expected));
        end
    endtask

    // Modulo 2^32 sum of one core's slice
    function automatic logic [31:0] slice_sum(input int core, input logic [15:0] base,
                                              input int wc);
        logic [31:0] s;
        logic [15:0] a;
        s = '0;
        for (int k = 0; k < wc; k++) begin
            a = base + 16'(core * wc) + 16'(k);
            s = s + mem_model.mem[a];
        end
        return s;
    endfunction

    task automatic dcr_write(input dcr_addr_e addr, input logic [31:0] data);
        @(posedge clk);
        dcr <= '{valid: 1'b1, addr: addr, data: data};
        @(posedge clk);
        dcr <= '0;
    endtask

    task automatic setup_job(input logic [15:0] base, input logic [15:0] result);
        dcr_write(DCR_BASE, 32'(base));
        dcr_write(DCR_RESULT, 32'(result));
        mem_model.wr_log.delete();
    endtask

    task automatic start_job(input logic [7:0] mask, input int wc);
        start_cmd_t cmd;
        cmd.reserved   = '0;
        cmd.word_count = 12'(wc);
        cmd.core_mask  = mask;
        dcr_write(DCR_START, cmd);
    endtask

    // Busy must rise for the job, then fall when it ends
    task automatic wait_idle();
        int n;
        n = 0;
        while (busy !== 1'b1) begin
            @(posedge clk);
            n++;
            if (n > 20) stop_with_error("busy never rose after the start command");
        end
        n = 0;
        while (busy !== 1'b0) begin
            @(posedge clk);
            n++;
            if (n > 2000) stop_with_error("timeout waiting for busy to fall");
        end
    endtask

    task automatic run_job(input logic [7:0] mask, input int wc);
        start_job(mask, wc);
        wait_idle();
    endtask

    // Finds the write to addr in the log, checks its data and tag and removes it
    task automatic expect_write(input logic [15:0] addr, input int core,
                                input logic [31:0] data);
        mem_req_t w;
        int hit;
        hit = -1;
        for (int j = 0; j < mem_model.wr_log.size(); j++) begin
            w = mem_model.wr_log[j];
            if (hit < 0 && w.addr == addr) hit = j;
        end
        if (hit < 0) begin
            stop_with_error($sformatf("no write seen at address %h", addr));
        end else begin
            w = mem_model.wr_log[hit];
            check_eq("mem_req.data", w.data, data);
            check_eq("mem_req.tag", 32'(w.tag), 32'(core));
            mem_model.wr_log.delete(hit);
        end
    endtask

    task automatic check_writes(input logic [7:0] mask, input logic [15:0] base,
                                input logic [15:0] result, input int wc);
        int n;
        n = 0;
        for (int i = 0; i < N; i++) if (mask[i]) n++;
        check_eq("write count", 32'(mem_model.wr_log.size()), 32'(n));
        for (int i = 0; i < N; i++) begin
            if (mask[i]) expect_write(result + 16'(i), i, slice_sum(i, base, wc));
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////

    task automatic test_reset_idle();
        repeat (10) begin
            @(posedge clk);
            check_eq("busy", 32'(busy), 32'd0);
            check_eq("mem_req.valid", 32'(mem_req.valid), 32'd0);
        end
    endtask

    task automatic test_single_core();
        setup_job(16'h0100, 16'h8000);
        run_job(8'h01, 5);
        check_writes(8'h01, 16'h0100, 16'h8000, 5);
    endtask

    task automatic test_all_cores();
        setup_job(16'h0200, 16'h8010);
        run_job(8'h03, 8);
        check_writes(8'h03, 16'h0200, 16'h8010, 8);
    endtask

    task automatic test_wrap();
        for (int a = 16'h0300; a < 16'h0306; a++) mem_model.mem[a] = 32'hFFFF_FFFF;
        setup_job(16'h0300, 16'h8020);
        run_job(8'h03, 3);
        check_writes(8'h03, 16'h0300, 16'h8020, 3);
    endtask

    task automatic test_start_while_busy();
        setup_job(16'h0400, 16'h8030);
        start_job(8'h03, 6);
        // Lands while both cores are still reading
        start_job(8'h03, 2);
        wait_idle();
        check_writes(8'h03, 16'h0400, 16'h8030, 6);
        setup_job(16'h0500, 16'h8040);
        run_job(8'h03, 4);
        check_writes(8'h03, 16'h0500, 16'h8040, 4);
    endtask

    task automatic test_zero_count();
        setup_job(16'h0600, 16'h8050);
        run_job(8'h03, 0);
        check_writes(8'h03, 16'h0600, 16'h8050, 0);
    endtask

    initial begin
        reset <= 1'b1;
        dcr   <= '0;
        lcg_state = 32'h5c7b7cf2;
        for (int a = 0; a < (1 << `SOCK_ADDR_W); a++) begin
            lcg_state = lcg_next(lcg_state);
            mem_model.mem[a] = lcg_state;
        end
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        test_reset_idle();
        test_single_core();
        test_all_cores();
        test_wrap();
        test_start_while_busy();
        test_zero_count();
        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* verif/sock_mem_model.sv */
`include "sock_params.svh"

`default_nettype none

module sock_mem_model import sock_mem_pkg::*; (
    input  wire           clk,
    input  wire           reset,
    input  wire mem_req_t mem_req,
    output mem_rsp_t      mem_rsp
);

    localparam int DEPTH = 1 << `SOCK_ADDR_W;

    // Word storage, filled by the testbench before reset ends
    logic [`SOCK_DATA_W-1:0] mem [0:DEPTH-1];

    // Every write in arrival order
    mem_req_t wr_log [$];

    mem_rsp_t stage;

    ////////////////////////////////////////////////////////////
    // Read pipeline, two cycles, one new read per cycle
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            stage   <= '0;
            mem_rsp <= '0;
        end else begin
            stage.valid <= mem_req.valid && !mem_req.write;
            stage.data  <= mem[mem_req.addr];
            stage.tag   <= mem_req.tag;
            mem_rsp     <= stage;
        end
    end

    // Write log
    always @(posedge clk) begin
        if (!reset && mem_req.valid && mem_req.write) begin
            wr_log.push_back(mem_req);
        end
    end

endmodule

`default_nettype wire

/* hw/sock_socket.sv */
`include "sock_params.svh"

`default_nettype none

module sock_socket import sock_mem_pkg::*; import sock_dcr_pkg::*; (
    // Clock
    input  wire           clk,
    input  wire           reset,

    // DCRs
    input  wire dcr_req_t dcr,

    // Memory
    output wire mem_req_t mem_req,
    input  wire mem_rsp_t mem_rsp,

    // Status
    output logic          busy
);

    wire job_cfg_t                  cfg;
    wire [`SOCK_SIZE-1:0]           core_start;
    wire mem_req_t [`SOCK_SIZE-1:0] core_req;
    wire mem_rsp_t [`SOCK_SIZE-1:0] core_rsp;
    wire [`SOCK_SIZE-1:0]           core_busy;
    wire                            arb_pending;

    sock_dcr_regs dcr_regs (
        .clk   (clk),
        .reset (reset),
        .dcr   (dcr),
        .cfg   (cfg),
        .start (core_start)
    );

    // One core per memory tag
    for (genvar i = 0; i < `SOCK_SIZE; ++i) begin : g_core
        sock_core #(
            .CORE_ID (i)
        ) core (
            .clk   (clk),
            .reset (reset),
            .cfg   (cfg),
            .start (core_start[i]),
            .req   (core_req[i]),
            .rsp   (core_rsp[i]),
            .busy  (core_busy[i])
        );
    end

    sock_mem_arb mem_arb (
        .clk      (clk),
        .reset    (reset),
        .core_req (core_req),
        .core_rsp (core_rsp),
        .mem_req  (mem_req),
        .mem_rsp  (mem_rsp),
        .pending  (arb_pending)
    );

    // Held high until cores and arbiter are both drained
    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b0;
        end else begin
            busy <= (|core_busy) || arb_pending;
        end
    end

endmodule

`default_nettype wire

/* hw/sock_mem_arb.sv */
`include "sock_params.svh"

`default_nettype none

module sock_mem_arb import sock_mem_pkg::*; (
    // Clock
    input  wire                             clk,
    input  wire                             reset,

    // Core side
    input  wire mem_req_t [`SOCK_SIZE-1:0]  core_req,
    output mem_rsp_t [`SOCK_SIZE-1:0]       core_rsp,

    // Memory side
    output mem_req_t                        mem_req,
    input  wire mem_rsp_t                   mem_rsp,

    // Any slot still full
    output logic                            pending
);

    localparam int N  = `SOCK_SIZE;
    localparam int IW = (N > 1) ? $clog2(N) : 1;
    localparam int TW = `SOCK_TAG_W;

    mem_req_t [N-1:0] slot;
    logic [IW-1:0]    rr_ptr;
    logic             grant_vld;
    logic [IW-1:0]    grant_idx;
    mem_rsp_t         rsp_q;

    ////////////////////////////////////////////////////////////
    // Round-robin pick
    ////////////////////////////////////////////////////////////

    always_comb begin
        int idx;
        grant_vld = 1'b0;
        grant_idx = rr_ptr;
        // Search starts at the pointer and wraps
        for (int k = 0; k < N; k++) begin
            idx = (int'(rr_ptr) + k) % N;
            if (!grant_vld && slot[idx].valid) begin
                grant_vld = 1'b1;
                grant_idx = IW'(idx);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < N; i++) begin
                slot[i].valid <= 1'b0;
            end
            rr_ptr  <= '0;
            mem_req <= '0;
        end else begin
            // Drain the winner, then capture, so a new request wins a tie
            if (grant_vld) begin
                slot[grant_idx].valid <= 1'b0;
                rr_ptr <= (int'(grant_idx) == N - 1) ? '0 : grant_idx + IW'(1);
            end
            for (int i = 0; i < N; i++) begin
                if (core_req[i].valid) begin
                    slot[i] <= core_req[i];
                end
            end
            mem_req       <= slot[grant_idx];
            mem_req.valid <= grant_vld;
        end
    end

    ////////////////////////////////////////////////////////////
    // Response return
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            rsp_q <= '0;
        end else begin
            rsp_q <= mem_rsp;
        end
    end

    // Only the tag owner sees valid
    always_comb begin
        for (int i = 0; i < N; i++) begin
            core_rsp[i]       = rsp_q;
            core_rsp[i].valid = rsp_q.valid && (rsp_q.tag == TW'(i));
        end
    end

    always_comb begin
        pending = 1'b0;
        for (int i = 0; i < N; i++) begin
            pending = pending | slot[i].valid;
        end
    end

endmodule

`default_nettype wire

/* hw/sock_core.sv */
`include "sock_params.svh"

`default_nettype none

module sock_core import sock_mem_pkg::*; import sock_dcr_pkg::*; #(
    parameter int CORE_ID = 0
) (
    // Clock
    input  wire           clk,
    input  wire           reset,

    // Job control
    input  wire job_cfg_t cfg,
    input  wire           start,

    // Memory
    output mem_req_t      req,
    input  wire mem_rsp_t rsp,

    // Status
    output logic          busy
);

    localparam int AW = `SOCK_ADDR_W;
    localparam int DW = `SOCK_DATA_W;
    localparam int TW = `SOCK_TAG_W;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_READ,
        ST_WAIT,
        ST_WRITE
    } state_e;

    state_e                 state;
    logic [AW-1:0]          rd_addr;
    logic [AW-1:0]          wr_addr;
    logic [CMD_COUNT_W-1:0] remain;
    logic [DW-1:0]          acc;
    logic [AW-1:0]          slice_base;

    // First word of this core's slice
    assign slice_base = cfg.base + AW'(CORE_ID) * AW'(cfg.word_count);

    ////////////////////////////////////////////////////////////
    // Job FSM
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    // Config is copied here, later DCR writes don't matter
                    if (start) begin
                        rd_addr <= slice_base;
                        wr_addr <= cfg.result + AW'(CORE_ID);
                        remain  <= cfg.word_count;
                        acc     <= '0;
                        state   <= (cfg.word_count == '0) ? ST_WRITE : ST_READ;
                    end
                end
                ST_READ: begin
                    state <= ST_WAIT;
                end
                ST_WAIT: begin
                    if (rsp.valid) begin
                        acc     <= acc + rsp.data;
                        rd_addr <= rd_addr + AW'(1);
                        remain  <= remain - CMD_COUNT_W'(1);
                        // Last word goes straight to the result write
                        state   <= (remain == CMD_COUNT_W'(1)) ? ST_WRITE : ST_READ;
                    end
                end
                ST_WRITE: begin
                    state <= ST_IDLE;
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // Request is held for one cycle in READ or WRITE
    always_comb begin
        req       = '0;
        req.valid = (state == ST_READ) || (state == ST_WRITE);
        req.write = (state == ST_WRITE);
        req.addr  = (state == ST_WRITE) ? wr_addr : rd_addr;
        req.data  = acc;
        req.tag   = TW'(CORE_ID);
    end

    assign busy = (state != ST_IDLE);

endmodule

`default_nettype wire

/* hw/sock_dcr_regs.sv */
`include "sock_params.svh"

`default_nettype none

module sock_dcr_regs import sock_dcr_pkg::*; (
    // Clock
    input  wire                   clk,
    input  wire                   reset,

    // Host DCR writes
    input  wire dcr_req_t         dcr,

    // To the cores
    output job_cfg_t              cfg,
    output logic [`SOCK_SIZE-1:0] start
);

    localparam int AW = `SOCK_ADDR_W;
    localparam int N  = `SOCK_SIZE;

    dcr_data_u wdata;

    // Decode the incoming word both ways
    assign wdata = dcr.data;

    ////////////////////////////////////////////////////////////
    // Register writes
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            cfg   <= '0;
            start <= '0;
        end else begin
            // Strobes last a single cycle
            start <= '0;
            if (dcr.valid) begin
                case (dcr.addr)
                    DCR_BASE: begin
                        cfg.base <= wdata.raw[AW-1:0];
                    end
                    DCR_RESULT: begin
                        cfg.result <= wdata.raw[AW-1:0];
                    end
                    DCR_START: begin
                        cfg.word_count <= wdata.cmd.word_count;
                        // Mask bits above the core count are ignored
                        start <= wdata.cmd.core_mask[N-1:0];
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

/* hw/sock_dcr_pkg.sv */
`include "sock_params.svh"

`default_nettype none

package sock_dcr_pkg;

    // Width of the word count in a start command
    localparam int CMD_COUNT_W = 12;

    // DCR register map
    typedef enum logic [1:0] {
        DCR_BASE   = 2'd0,
        DCR_RESULT = 2'd1,
        DCR_START  = 2'd2
    } dcr_addr_e;

    // Host write strobe
    typedef struct packed {
        logic        valid;
        dcr_addr_e   addr;
        logic [31:0] data;
    } dcr_req_t;

    // Start command layout, mask in the low byte
    typedef struct packed {
        logic [11:0]            reserved;
        logic [CMD_COUNT_W-1:0] word_count;
        logic [7:0]             core_mask;
    } start_cmd_t;

    // Same DCR word seen as an address or as a command
    typedef union packed {
        logic [31:0] raw;
        start_cmd_t  cmd;
    } dcr_data_u;

    // Job setup shared by all cores
    typedef struct packed {
        logic [`SOCK_ADDR_W-1:0] base;
        logic [`SOCK_ADDR_W-1:0] result;
        logic [CMD_COUNT_W-1:0]  word_count;
    } job_cfg_t;

endpackage

`default_nettype wire

/* hw/sock_mem_pkg.sv */
`include "sock_params.svh"

`default_nettype none

package sock_mem_pkg;

    ////////////////////////////////////////////////////////////
    // Memory bus types
    ////////////////////////////////////////////////////////////

    // One word per request, read or write
    typedef struct packed {
        logic                    valid;
        logic                    write;
        logic [`SOCK_ADDR_W-1:0] addr;
        logic [`SOCK_DATA_W-1:0] data;
        logic [`SOCK_TAG_W-1:0]  tag;
    } mem_req_t;

    // Read data, returned with the tag of its request
    typedef struct packed {
        logic                    valid;
        logic [`SOCK_DATA_W-1:0] data;
        logic [`SOCK_TAG_W-1:0]  tag;
    } mem_rsp_t;

endpackage

`default_nettype wire

/* hw/sock_params.svh */
`ifndef SOCK_PARAMS_SVH
`define SOCK_PARAMS_SVH

////////////////////////////////////////////////////////////
// Socket sizing
////////////////////////////////////////////////////////////

// Cores sharing the memory port
`define SOCK_SIZE 2

// Word address into the socket memory
`define SOCK_ADDR_W 16

// Memory data word
`define SOCK_DATA_W 32

// Request tag, wide enough for a core index
`define SOCK_TAG_W 1

`endif
